/* sources.f */
src/rf_data_pkg.sv
src/rf_index_pkg.sv
src/rf_write_decoder.sv
src/rf_bank.sv
src/rf_read_select.sv
src/register_file.sv
tb/register_file_tb.sv

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

// 32 x 32 register file, one write port and two read ports
// storage is split into BANK_COUNT identical banks (1, 2, 4 or 8)
module register_file
  import rf_data_pkg::*;
  import rf_index_pkg::*;
#(
  parameter int  BANK_COUNT    = 4,
  localparam int REGS_PER_BANK = REG_COUNT / BANK_COUNT,
  localparam int IDX_WIDTH     = $clog2(REGS_PER_BANK)
) (
  input  logic     CLK,
  input  logic     chknRST,
  input  logic     WEN,
  input  reg_sel_t wsel,
  input  word_t    wdat,
  input  reg_sel_t rsel1,
  input  reg_sel_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  // write side, one strobe per bank and a shared index
  logic [BANK_COUNT-1:0] bank_wen;
  logic [IDX_WIDTH-1:0]  bank_widx;

  // read side, shared in-bank indices
  logic [IDX_WIDTH-1:0]  bank_ridx1;
  logic [IDX_WIDTH-1:0]  bank_ridx2;

  // bank outputs, one word per bank, bank 0 in the low word
  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdat1;
  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdat2;

  rf_write_decoder #(
    .BANK_COUNT (BANK_COUNT)
  ) rf_write_decoder_inst (
    .WEN       (WEN),
    .wsel      (wsel),
    .bank_wen  (bank_wen),
    .bank_widx (bank_widx)
  );

  // write data fans out to every bank unchanged
  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    rf_bank #(
      .BANK_COUNT (BANK_COUNT)
    ) rf_bank_inst (
      .CLK     (CLK),
      .chknRST (chknRST),
      .wen     (bank_wen[b]),
      .widx    (bank_widx),
      .wdat    (wdat),
      .ridx1   (bank_ridx1),
      .ridx2   (bank_ridx2),
      .rdat1   (bank_rdat1[b*DATA_WIDTH +: DATA_WIDTH]),
      .rdat2   (bank_rdat2[b*DATA_WIDTH +: DATA_WIDTH])
    );
  end

  rf_read_select #(
    .BANK_COUNT (BANK_COUNT)
  ) rf_read_select_inst (
    .rsel1      (rsel1),
    .rsel2      (rsel2),
    .bank_ridx1 (bank_ridx1),
    .bank_ridx2 (bank_ridx2),
    .bank_rdat1 (bank_rdat1),
    .bank_rdat2 (bank_rdat2),
    .rdat1      (rdat1),
    .rdat2      (rdat2)
  );

endmodule

`default_nettype wire

/* src/rf_bank.sv */
`timescale 1ns/1ps
`default_nettype none

// one slice of the register file
// one write per cycle, two independent combinational reads
module rf_bank
  import rf_data_pkg::*;
  import rf_index_pkg::*;
#(
  parameter int  BANK_COUNT    = 4,
  localparam int REGS_PER_BANK = REG_COUNT / BANK_COUNT,
  localparam int IDX_WIDTH     = $clog2(REGS_PER_BANK)
) (
  input  logic                 CLK,
  input  logic                 chknRST,
  input  logic                 wen,
  input  logic [IDX_WIDTH-1:0] widx,
  input  word_t                wdat,
  input  logic [IDX_WIDTH-1:0] ridx1,
  input  logic [IDX_WIDTH-1:0] ridx2,
  output word_t                rdat1,
  output word_t                rdat2
);

  word_t regs [REGS_PER_BANK];

  // reset wins over a write in the same cycle
  always_ff @(posedge CLK) begin
    if (!chknRST) begin
      for (int i = 0; i < REGS_PER_BANK; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[widx] <= wdat;
    end
  end

  // new data shows up only after the edge, no bypass
  assign rdat1 = regs[ridx1];
  assign rdat2 = regs[ridx2];

endmodule

`default_nettype wire

/* src/rf_data_pkg.sv */
`default_nettype none

// data word carried by the write port and both read ports
package rf_data_pkg;

  // one register holds a full processor word
  localparam int DATA_WIDTH = 32;

  typedef logic [DATA_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

/* src/rf_index_pkg.sv */
`default_nettype none

// register numbering and its split into bank and in-bank index
package rf_index_pkg;

  // 5-bit register numbers, registers 0 to 31
  localparam int SEL_WIDTH = 5;
  localparam int REG_COUNT = 1 << SEL_WIDTH;

  typedef logic [SEL_WIDTH-1:0] reg_sel_t;

  // bank that owns a register, taken from the high bits
  // bank_count is a power of two, so this folds to a bit slice
  function automatic int bank_of(input reg_sel_t sel, input int bank_count);
    return int'(sel) / (REG_COUNT / bank_count);
  endfunction

  // position of a register inside its bank, the low bits
  function automatic int idx_of(input reg_sel_t sel, input int bank_count);
    return int'(sel) % (REG_COUNT / bank_count);
  endfunction

endpackage

`default_nettype wire

/* src/rf_read_select.sv */
`timescale 1ns/1ps
`default_nettype none

// splits both read selects and picks the owning bank's word per port
module rf_read_select
  import rf_data_pkg::*;
  import rf_index_pkg::*;
#(
  parameter int  BANK_COUNT    = 4,
  localparam int REGS_PER_BANK = REG_COUNT / BANK_COUNT,
  localparam int IDX_WIDTH     = $clog2(REGS_PER_BANK)
) (
  input  reg_sel_t                         rsel1,
  input  reg_sel_t                         rsel2,
  output logic [IDX_WIDTH-1:0]             bank_ridx1,
  output logic [IDX_WIDTH-1:0]             bank_ridx2,
  input  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdat1,
  input  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdat2,
  output word_t                            rdat1,
  output word_t                            rdat2
);

  int rbank1;
  int rbank2;

  // low bits go out to every bank
  assign bank_ridx1 = IDX_WIDTH'(idx_of(rsel1, BANK_COUNT));
  assign bank_ridx2 = IDX_WIDTH'(idx_of(rsel2, BANK_COUNT));

  // high bits name the bank, always 0 with a single bank
  assign rbank1 = bank_of(rsel1, BANK_COUNT);
  assign rbank2 = bank_of(rsel2, BANK_COUNT);

  // output mux per port, the two ports do not interact
  always_comb begin
    rdat1 = '0;
    rdat2 = '0;
    for (int b = 0; b < BANK_COUNT; b++) begin
      if (rbank1 == b) begin
        rdat1 = bank_rdat1[b*DATA_WIDTH +: DATA_WIDTH];
      end
      if (rbank2 == b) begin
        rdat2 = bank_rdat2[b*DATA_WIDTH +: DATA_WIDTH];
      end
    end
  end

endmodule

`default_nettype wire

/* src/rf_write_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

// turns the write select into one strobe per bank plus the in-bank index
module rf_write_decoder
  import rf_index_pkg::*;
#(
  parameter int  BANK_COUNT    = 4,
  localparam int REGS_PER_BANK = REG_COUNT / BANK_COUNT,
  localparam int IDX_WIDTH     = $clog2(REGS_PER_BANK)
) (
  input  logic                  WEN,
  input  reg_sel_t              wsel,
  output logic [BANK_COUNT-1:0] bank_wen,
  output logic [IDX_WIDTH-1:0]  bank_widx
);

  logic write_ok;
  int   wbank;

  // register 0 never takes a write
  // it keeps its reset value, so the read side needs no check
  assign write_ok = WEN && (wsel != '0);

  // bank number from the high bits
  assign wbank = bank_of(wsel, BANK_COUNT);

  // in-bank index goes to every bank, only the strobed one uses it
  assign bank_widx = IDX_WIDTH'(idx_of(wsel, BANK_COUNT));

  // one-hot strobe, all low when no write is allowed
  always_comb begin
    for (int b = 0; b < BANK_COUNT; b++) begin
      bank_wen[b] = write_ok && (wbank == b);
    end
  end

endmodule

`default_nettype wire

/* tb/register_file_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// directed tests for the banked register file
module register_file_tb
  import rf_data_pkg::*;
  import rf_index_pkg::*;
();

  localparam int  CLK_PERIOD   = 8;
  localparam int  RESET_CYCLES = 4;
  localparam int  BANKS        = 4;
  localparam real CHECK_DELAY  = 2.0;
  // a running clock always gives a falling edge well inside one window
  localparam real EDGE_WINDOW  = 12.0;
  localparam int  EDGE_TRIES   = 4;
  localparam int  RANDOM_CYCLES = 200;
  localparam logic [15:0] LFSR_SEED = 16'd12492;
  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic     CLK;
  logic     chknRST;
  logic     WEN;
  reg_sel_t wsel;
  word_t    wdat;
  reg_sel_t rsel1;
  reg_sel_t rsel2;
  word_t    rdat1;
  word_t    rdat2;

  // reference model with entry 0 held at zero
  word_t model [REG_COUNT];

  logic [15:0] lfsr;
  int check_count    = 0;
  int mismatch_count = 0;
  int timeout_count  = 0;

  register_file #(
    .BANK_COUNT (BANKS)
  ) register_file_inst (
    .CLK     (CLK),
    .chknRST (chknRST),
    .WEN     (WEN),
    .wsel    (wsel),
    .wdat    (wdat),
    .rsel1   (rsel1),
    .rsel2   (rsel2),
    .rdat1   (rdat1),
    .rdat2   (rdat2)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  // model follows the register file rules at every rising edge
  always @(posedge CLK) begin
    if (!chknRST) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        model[i] <= '0;
      end
    end else if (WEN) begin
      model[wsel] <= wdat;
    end
    model[0] <= '0;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic out_bit;
    out_bit = state[0];
    state   = state >> 1;
    if (out_bit) begin
      state = state ^ LFSR_TAPS;
    end
    return state;
  endfunction

  function automatic word_t next_random(input int nbits);
    word_t value;
    value = '0;
    for (int k = 0; k < nbits; k++) begin
      lfsr     = lfsr_next(lfsr);
      value[k] = lfsr[0];
    end
    return value;
  endfunction

  function automatic reg_sel_t random_sel();
    return reg_sel_t'(next_random(SEL_WIDTH));
  endfunction

  task automatic finish_run();
    $display("checks %0d, mismatches %0d, timeouts %0d",
             check_count, mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // each try waits one window for the falling edge
  task automatic wait_fall();
    int      tries;
    bit      seen;
    realtime start;
    tries = 0;
    seen  = 1'b0;
    while (!seen && tries < EDGE_TRIES) begin
      start = $realtime;
      fork
        @(negedge CLK);
        #(EDGE_WINDOW);
      join_any
      disable fork;
      seen  = ($realtime - start) < EDGE_WINDOW;
      tries = tries + 1;
    end
    if (!seen) begin
      timeout_count = timeout_count + 1;
      $display("clock stopped: no falling edge of CLK seen in %0d tries at time %0t",
               tries, $time);
      finish_run();
    end
  endtask

  task automatic check_word(input word_t expected, input word_t actual, input reg_sel_t sel);
    check_count = check_count + 1;
    if (actual !== expected) begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch at time %0t: register %0d expected %h got %h",
               $time, sel, expected, actual);
    end
  endtask

  // let the combinational read path settle, then compare both ports
  task automatic check_reads(input word_t exp1, input word_t exp2);
    #(CHECK_DELAY);
    check_word(exp1, rdat1, rsel1);
    check_word(exp2, rdat2, rsel2);
  endtask

  task automatic check_reads_model();
    #(CHECK_DELAY);
    check_word(model[rsel1], rdat1, rsel1);
    check_word(model[rsel2], rdat2, rsel2);
  endtask

  task automatic apply_reset();
    chknRST = 1'b0;
    WEN     = 1'b0;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      wait_fall();
    end
    chknRST = 1'b1;
  endtask

  // all 32 selects on each port with the ports walking in opposite directions
  task automatic sweep_reads(input bit zeros);
    for (int i = 0; i < REG_COUNT; i++) begin
      wait_fall();
      WEN   = 1'b0;
      rsel1 = reg_sel_t'(i);
      rsel2 = reg_sel_t'(REG_COUNT - 1 - i);
      if (zeros) begin
        check_reads('0, '0);
      end else begin
        check_reads_model();
      end
    end
  endtask

  task automatic reads_zero_after_reset();
    sweep_reads(1'b1);
  endtask

  task automatic write_all_read_back();
    word_t exp1;
    word_t exp2;
    for (int i = 0; i < REG_COUNT; i++) begin
      wait_fall();
      WEN  = 1'b1;
      wsel = reg_sel_t'(i);
      wdat = word_t'(i + 1);
    end
    wait_fall();
    WEN = 1'b0;
    // second port reads a different register in the same cycle
    for (int i = 0; i < REG_COUNT; i++) begin
      wait_fall();
      rsel1 = reg_sel_t'(i);
      rsel2 = reg_sel_t'((i + 7) % REG_COUNT);
      exp1  = (rsel1 == 0) ? word_t'(0) : word_t'(rsel1) + 1;
      exp2  = (rsel2 == 0) ? word_t'(0) : word_t'(rsel2) + 1;
      check_reads(exp1, exp2);
    end
  endtask

  task automatic hold_with_write_disabled();
    reg_sel_t prev_sel;
    prev_sel = wsel;
    for (int c = 0; c < 8; c++) begin
      wait_fall();
      WEN   = 1'b0;
      // register aimed at one edge earlier
      rsel1 = prev_sel;
      wsel  = random_sel();
      wdat  = next_random(DATA_WIDTH);
      rsel2 = random_sel();
      prev_sel = wsel;
      check_reads_model();
    end
    wait_fall();
    sweep_reads(1'b0);
  endtask

  task automatic write_visible_after_edge();
    word_t old_val;
    word_t new_val;
    old_val = model[13];
    new_val = next_random(DATA_WIDTH);
    if (new_val == old_val) begin
      new_val = ~old_val;
    end
    wait_fall();
    WEN   = 1'b1;
    wsel  = reg_sel_t'(13);
    wdat  = new_val;
    rsel1 = reg_sel_t'(13);
    rsel2 = reg_sel_t'(13);
    // write not committed yet so both ports still see the old word
    check_reads(old_val, old_val);
    wait_fall();
    WEN = 1'b0;
    check_reads(new_val, new_val);
  endtask

  task automatic random_traffic();
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      wait_fall();
      WEN   = next_random(1) != 0;
      wsel  = random_sel();
      wdat  = next_random(DATA_WIDTH);
      rsel1 = random_sel();
      rsel2 = random_sel();
      // make sure register 0 sees writes now and then
      if (n % 25 == 0) begin
        WEN  = 1'b1;
        wsel = '0;
      end
      check_reads_model();
    end
    wait_fall();
    WEN = 1'b0;
    sweep_reads(1'b0);
  endtask

  task automatic reset_clears_writes();
    word_t val;
    val = next_random(DATA_WIDTH) | word_t'(1);
    wait_fall();
    WEN  = 1'b1;
    wsel = reg_sel_t'(20);
    wdat = val;
    wait_fall();
    WEN   = 1'b0;
    rsel1 = reg_sel_t'(20);
    rsel2 = reg_sel_t'(0);
    check_reads(val, '0);
    // one reset cycle with a write pending at the same edge
    wait_fall();
    chknRST = 1'b0;
    WEN     = 1'b1;
    wsel    = reg_sel_t'(5);
    wdat    = next_random(DATA_WIDTH);
    wait_fall();
    chknRST = 1'b1;
    WEN     = 1'b0;
    sweep_reads(1'b1);
  endtask

  initial begin
    chknRST = 1'b0;
    WEN     = 1'b0;
    wsel    = '0;
    wdat    = '0;
    rsel1   = '0;
    rsel2   = '0;
    lfsr    = LFSR_SEED;
    apply_reset();
    reads_zero_after_reset();
    write_all_read_back();
    hold_with_write_disabled();
    write_visible_after_edge();
    random_traffic();
    reset_clears_writes();
    finish_run();
  end

endmodule

`default_nettype wire
